// File: hw/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// system clock in Hz, one 100 ns period
`define UART_CLK_FREQ 10_000_000

// line rate in bits per second
`define UART_BAUD 115200

// receive samples per bit, power of two and at least 8
`define UART_OVERSAMPLE 8

// bit times of quiet line before the receiver calls it idle
`define UART_GAP_BITS 2

`endif

// File: hw/uartPkg.sv
`include "uart_settings.svh"

package uartPkg;

	////////////////////////////////////////
	// widths derived from the settings
	localparam int OVER_W = $clog2(`UART_OVERSAMPLE);	// position inside one bit
	localparam int GAP_TICKS = `UART_GAP_BITS * `UART_OVERSAMPLE;	// oversample ticks per gap
	localparam int GAP_W = $clog2(GAP_TICKS) + 1;	// one spare bit so the count can saturate

	////////////////////////////////////////
	// data and counter types
	typedef logic [7:0] uartByte_t;	// one frame payload
	typedef logic [OVER_W-1:0] overCount_t;
	typedef logic [GAP_W-1:0] gapCount_t;

	////////////////////////////////////////
	// state machines
	// receive side
	typedef enum logic [1:0] {
		rxIdle,	// waiting for a falling edge
		rxStart,	// lining up on the middle of the start bit
		rxData,	// eight data bits, LSB first
		rxStop	// stop bit check
	} rxState_t;

	// transmit side, each state names what goes out at the next tick
	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txState_t;

endpackage

// File: hw/baudTickGen.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

// fractional rate generator
// phase advances by baud*MULT every clock and wraps modulo the clock frequency,
// so ticks land on the exact average rate with at most one cycle of jitter
module baudTickGen #(
	parameter int MULT = 1	// ticks per bit time
) (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	localparam int MOD = `UART_CLK_FREQ;	// accumulator modulus
	localparam int INC = `UART_BAUD * MULT;	// step per clock
	localparam int ACC_W = $clog2(MOD) + 1;	// headroom for phase + INC

	logic [ACC_W-1:0] phase;
	logic [ACC_W-1:0] phaseSum;
	logic wrap;	// overflow of the modulo accumulator

	assign phaseSum = phase + ACC_W'(INC);
	assign wrap = (phaseSum >= ACC_W'(MOD));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// drop one full turn on overflow, keep the remainder
			phase <= wrap ? (phaseSum - ACC_W'(MOD)) : phaseSum;
			tick <= wrap;	// registered so the strobe is clean
		end
	end

	// rate must stay under half the clock for the tick to be a pulse
	tickIsPulse: assert property (
		@(posedge clk) disable iff (reset)
		tick |=> !tick
	);

endmodule

// File: hw/uartReceiver.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

// oversampling receiver, 8N1
// line is synchronized and filtered on rxTick, then sampled at mid-bit
// state literals carry the package prefix since several match port names
module uartReceiver import uartPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rxTick,	// UART_OVERSAMPLE ticks per bit
	input  logic rxd,
	output uartByte_t rxData,	// last good byte
	output logic rxDataReady,
	output logic rxFrameError,
	output logic rxIdle,	// level, quiet line
	output logic rxEndOfPacket	// pulse as rxIdle rises
);

	localparam overCount_t MID = overCount_t'(`UART_OVERSAMPLE / 2 - 1);	// sample tick

	// parameter sanity at elaboration
	if (`UART_CLK_FREQ < `UART_BAUD * `UART_OVERSAMPLE)
	begin : gClkCheck
		$error("clock too slow for baud rate and oversampling");
	end
	if (`UART_OVERSAMPLE < 8 || (`UART_OVERSAMPLE & (`UART_OVERSAMPLE - 1)) != 0)
	begin : gOverCheck
		$error("oversampling must be a power of two and at least 8");
	end

	logic [1:0] sync;	// two stage synchronizer
	logic [1:0] filterCnt;	// saturating majority counter
	logic rxBit;	// filtered line
	overCount_t overCnt;
	logic sampleNow;
	rxState_t state;
	logic [2:0] bitIdx;
	uartByte_t shiftReg;
	gapCount_t gapCnt;

	////////////////////////////////////////
	// line conditioning
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sync <= 2'b11;	// idle line is high
			filterCnt <= 2'b11;
			rxBit <= 1'b1;
		end
		else if (rxTick)
		begin
			sync <= {sync[0], rxd};
			if (sync[1] && filterCnt != 2'b11)
				filterCnt <= filterCnt + 2'd1;
			else if (!sync[1] && filterCnt != 2'b00)
				filterCnt <= filterCnt - 2'd1;
			// only flip at full agreement
			if (filterCnt == 2'b11)
				rxBit <= 1'b1;
			else if (filterCnt == 2'b00)
				rxBit <= 1'b0;
		end
	end

	// bit position, held at zero while idle
	always_ff @(posedge clk)
	begin
		if (reset)
			overCnt <= '0;
		else if (rxTick)
			overCnt <= (state == uartPkg::rxIdle) ? '0 : overCnt + 1'b1;
	end

	assign sampleNow = rxTick && (overCnt == MID);

	////////////////////////////////////////
	// frame state machine
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= uartPkg::rxIdle;
			bitIdx <= '0;
		end
		else
		begin
			case (state)
				uartPkg::rxIdle:
					if (!rxBit)
						state <= uartPkg::rxStart;	// falling edge
				uartPkg::rxStart:
					if (sampleNow)
					begin
						bitIdx <= '0;
						// start bit gone high again means a false start
						state <= rxBit ? uartPkg::rxIdle : uartPkg::rxData;
					end
				uartPkg::rxData:
					if (sampleNow)
					begin
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd7)
							state <= uartPkg::rxStop;
					end
				uartPkg::rxStop:
					if (sampleNow)
						state <= uartPkg::rxIdle;
				default: state <= uartPkg::rxIdle;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk)
	begin
		if (sampleNow && state == uartPkg::rxData)
			shiftReg <= {rxBit, shiftReg[7:1]};	// LSB first
		if (sampleNow && state == uartPkg::rxStop && rxBit)
			rxData <= shiftReg;	// only good frames update
	end

	// result strobes, one cycle after the stop sample
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rxDataReady <= 1'b0;
			rxFrameError <= 1'b0;
		end
		else
		begin
			rxDataReady <= sampleNow && state == uartPkg::rxStop && rxBit;
			rxFrameError <= sampleNow && state == uartPkg::rxStop && !rxBit;
		end
	end

	////////////////////////////////////////
	// gap detection
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gapCnt <= '0;
			rxEndOfPacket <= 1'b0;
		end
		else
		begin
			if (state != uartPkg::rxIdle)
				gapCnt <= '0;
			else if (rxTick && gapCnt != gapCount_t'(GAP_TICKS))
				gapCnt <= gapCnt + 1'b1;	// stops at the gap length
			// fires on the edge that saturates the count
			rxEndOfPacket <= state == uartPkg::rxIdle && rxTick
				&& gapCnt == gapCount_t'(GAP_TICKS - 1);
		end
	end

	assign rxIdle = (gapCnt == gapCount_t'(GAP_TICKS));

	rxResultExclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(rxDataReady && rxFrameError)
	);

	eopOnIdleRise: assert property (
		@(posedge clk) disable iff (reset)
		rxEndOfPacket |-> rxIdle && !$past(rxIdle)
	);

endmodule

// File: hw/uartTransmitter.sv
`timescale 1ns/100ps

// 8N1 transmitter paced by one tick per bit
// state names what the next tick puts on the line
module uartTransmitter import uartPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic txTick,	// one per bit time
	input  logic txStart,	// request, ignored while busy
	input  uartByte_t txData,
	output logic txd,	// registered line output
	output logic txBusy
);

	txState_t state;
	logic [2:0] bitIdx;	// data bit, reused to time the stop bit
	uartByte_t txShift;

	assign txBusy = (state != uartPkg::txIdle);

	////////////////////////////////////////
	// frame sequencing
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= uartPkg::txIdle;
			bitIdx <= '0;
			txd <= 1'b1;	// mark level
		end
		else
		begin
			case (state)
				uartPkg::txIdle:
					if (txStart)
						state <= uartPkg::txStart;	// accepted
				uartPkg::txStart:
					if (txTick)
					begin
						txd <= 1'b0;	// start bit
						bitIdx <= '0;
						state <= uartPkg::txData;
					end
				uartPkg::txData:
					if (txTick)
					begin
						txd <= txShift[0];
						bitIdx <= bitIdx + 3'd1;	// wraps to zero after bit 7
						if (bitIdx == 3'd7)
							state <= uartPkg::txStop;
					end
				uartPkg::txStop:
					if (txTick)
					begin
						// first tick raises the stop bit, second one ends it
						txd <= 1'b1;
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd1)
							state <= uartPkg::txIdle;
					end
				default:
				begin
					state <= uartPkg::txIdle;
					txd <= 1'b1;
				end
			endcase
		end
	end

	// payload shifter
	always_ff @(posedge clk)
	begin
		if (state == uartPkg::txIdle && txStart)
			txShift <= txData;	// capture on accept
		else if (state == uartPkg::txData && txTick)
			txShift <= {1'b1, txShift[7:1]};	// next bit to LSB
	end

	lineIdleHigh: assert property (
		@(posedge clk) disable iff (reset)
		(state == uartPkg::txIdle) |-> txd
	);

endmodule

// File: hw/uartPort.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

// full duplex port, separate rate generator per direction
module uartPort import uartPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rxd,
	input  logic txStart,
	input  uartByte_t txData,
	output logic txd,
	output logic txBusy,
	output uartByte_t rxData,
	output logic rxDataReady,
	output logic rxFrameError,
	output logic rxIdle,
	output logic rxEndOfPacket
);

	logic rxTick;	// oversample rate
	logic txTick;	// bit rate

	////////////////////////////////////////
	// rate generators
	baudTickGen #(.MULT(`UART_OVERSAMPLE)) u_rxTickGen (
		.clk   (clk),
		.reset (reset),
		.tick  (rxTick)
	);

	baudTickGen #(.MULT(1)) u_txTickGen (
		.clk   (clk),
		.reset (reset),
		.tick  (txTick)
	);

	////////////////////////////////////////
	// datapath
	uartReceiver u_uartReceiver (
		.clk           (clk),
		.reset         (reset),
		.rxTick        (rxTick),
		.rxd           (rxd),
		.rxData        (rxData),
		.rxDataReady   (rxDataReady),
		.rxFrameError  (rxFrameError),
		.rxIdle        (rxIdle),
		.rxEndOfPacket (rxEndOfPacket)
	);

	uartTransmitter u_uartTransmitter (
		.clk     (clk),
		.reset   (reset),
		.txTick  (txTick),
		.txStart (txStart),
		.txData  (txData),
		.txd     (txd),
		.txBusy  (txBusy)
	);

endmodule

// File: dv/uartPortTb.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uartPortTb import uartPkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 10;	// input skew after the rising edge
	localparam int RESET_CYCLES = 16;
	localparam int BIT_CLKS = `UART_CLK_FREQ / `UART_BAUD;	// line driver bit period
	localparam int BURST_LEN = 20;
	localparam logic [31:0] SEED = 32'hfd05_eb57;
	localparam int BYTES_SENT = 1 + BURST_LEN + 1 + 2;	// single, burst, bad frame, busy pair
	localparam int WATCHDOG_NS = (BYTES_SENT + 10) * 10 * BIT_CLKS * 2 * CLK_PERIOD
		+ RESET_CYCLES * CLK_PERIOD;

	logic clk, reset, rxd, txStart, txd, txBusy;
	logic rxDataReady, rxFrameError, rxIdle, rxEndOfPacket;
	uartByte_t txData, rxData;
	logic loopback;	// rxd from txd, else from the line driver
	logic lineDrv;
	logic burstActive;	// receive side must stay busy
	logic frameErrOk;	// a framing error is expected now
	logic [31:0] lcgState;
	uartByte_t expQ [0:63];	// expected bytes, in order
	int wrPtr = 0;
	int rdPtr = 0;	// also the count of good frames
	int ferrCount = 0;
	int eopCount = 0;
	int errCount = 0;
	int testErrBase;
	int testsRun = 0;
	int testsFailed = 0;
	string testName = "reset";

	assign rxd = loopback ? txd : lineDrv;

	uartPort u_uartPort (
		.clk           (clk),
		.reset         (reset),
		.rxd           (rxd),
		.txStart       (txStart),
		.txData        (txData),
		.txd           (txd),
		.txBusy        (txBusy),
		.rxData        (rxData),
		.rxDataReady   (rxDataReady),
		.rxFrameError  (rxFrameError),
		.rxIdle        (rxIdle),
		.rxEndOfPacket (rxEndOfPacket)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// error reporting
	function automatic void flagMismatch(input int expVal, input int actVal);
		$display("FAIL %s: expected %0h actual %0h", testName, expVal, actVal);
		errCount++;
	endfunction

	function automatic void flagError(input string msg);
		$display("ERROR %s: %s", testName, msg);
		errCount++;
	endfunction

	// receive side bookkeeping, pops the expected queue
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (rxDataReady)
				rdPtr <= rdPtr + 1;
			if (rxFrameError)
				ferrCount <= ferrCount + 1;
			if (rxEndOfPacket)
				eopCount <= eopCount + 1;
		end
	end

	////////////////////////////////////////
	// checking assertions
	byteWanted: assert property (@(posedge clk) disable iff (reset)
		rxDataReady |-> rdPtr != wrPtr)
		else flagError("rxDataReady with no byte outstanding");
	byteMatches: assert property (@(posedge clk) disable iff (reset)
		rxDataReady && rdPtr != wrPtr |-> rxData == expQ[rdPtr])
		else flagMismatch($sampled(expQ[rdPtr]), $sampled(rxData));
	readyPulse: assert property (@(posedge clk) disable iff (reset)
		rxDataReady |=> !rxDataReady) else flagError("rxDataReady longer than one cycle");
	ferrPulse: assert property (@(posedge clk) disable iff (reset)
		rxFrameError |=> !rxFrameError) else flagError("rxFrameError longer than one cycle");
	eopPulse: assert property (@(posedge clk) disable iff (reset)
		rxEndOfPacket |=> !rxEndOfPacket) else flagError("rxEndOfPacket longer than one cycle");
	ferrAllowed: assert property (@(posedge clk) disable iff (reset)
		rxFrameError |-> frameErrOk) else flagError("unexpected framing error");
	eopWithIdle: assert property (@(posedge clk) disable iff (reset)
		rxEndOfPacket == $rose(rxIdle))
		else flagError("end of packet not aligned with rxIdle rising");
	busyLine: assert property (@(posedge clk) disable iff (reset)
		burstActive |-> !rxIdle && !rxEndOfPacket) else flagError("line went idle inside burst");

	////////////////////////////////////////
	// stimulus helpers
	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic drawByte(output uartByte_t b);
		lcgState = lcgStep(lcgState);
		b = lcgState[23:16];	// upper bits, better spread
	endtask

	task automatic waitClocks(input int n);
		repeat (n) @(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic pulseStart(input uartByte_t b);
		txStart = 1'b1;
		txData = b;
		waitClocks(1);
		txStart = 1'b0;
	endtask

	// one accepted byte, queued as expected
	task automatic sendByte(input uartByte_t b);
		while (txBusy)
			waitClocks(1);
		expQ[wrPtr] = b;
		wrPtr++;
		pulseStart(b);
	endtask

	task automatic waitRx(input int target);
		while (rdPtr < target)
			waitClocks(1);
	endtask

	// 8N1 frame on the driver line, stop level selectable
	task automatic driveFrame(input uartByte_t b, input logic stopLevel);
		lineDrv = 1'b0;
		waitClocks(BIT_CLKS);
		for (int i = 0; i < 8; i++)
		begin
			lineDrv = b[i];	// LSB first
			waitClocks(BIT_CLKS);
		end
		lineDrv = stopLevel;
		waitClocks(BIT_CLKS);
		lineDrv = 1'b1;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrBase = errCount;
	endtask

	task automatic endTest;
		testsRun++;
		if (errCount == testErrBase)
			$display("test %0d %s: passed", testsRun, testName);
		else
		begin
			testsFailed++;
			$display("test %0d %s: failed, %0d errors", testsRun, testName,
				errCount - testErrBase);
		end
	endtask

	initial
	begin
		#WATCHDOG_NS;
		$display("watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	initial
	begin
		uartByte_t b;
		int base;
		int eopBase;

		reset = 1'b1;
		txStart = 1'b0;
		txData = '0;
		lineDrv = 1'b1;	// idle mark
		loopback = 1'b0;	// driver line until reset ends
		burstActive = 1'b0;
		frameErrOk = 1'b0;
		lcgState = SEED;
		waitClocks(RESET_CYCLES);
		reset = 1'b0;

		startTest("reset and single byte");
		loopback = 1'b1;
		assert (txd === 1'b1) else flagMismatch(1, txd);
		assert (txBusy === 1'b0) else flagMismatch(0, txBusy);
		drawByte(b);
		sendByte(b);
		waitRx(wrPtr);
		waitClocks(10 * BIT_CLKS);	// no second copy
		assert (rdPtr == wrPtr) else flagMismatch(wrPtr, rdPtr);
		endTest();

		startTest("random burst");
		base = rdPtr;
		fork
			for (int i = 0; i < BURST_LEN; i++)
			begin
				drawByte(b);
				sendByte(b);
			end
			begin
				waitRx(base + 1);
				burstActive = 1'b1;	// from first byte to last
				waitRx(base + BURST_LEN);
				burstActive = 1'b0;
			end
		join
		endTest();

		startTest("end of packet");
		base = eopCount;
		while (eopCount == base)
			waitClocks(1);
		waitClocks(4 * BIT_CLKS);
		assert (rxIdle === 1'b1) else flagMismatch(1, rxIdle);
		assert (eopCount == base + 1) else flagMismatch(base + 1, eopCount);
		endTest();

		startTest("framing error");
		loopback = 1'b0;	// both lines idle here
		frameErrOk = 1'b1;
		base = ferrCount;
		drawByte(b);
		driveFrame(b, 1'b0);
		waitClocks(4 * BIT_CLKS);	// false restart settles too
		frameErrOk = 1'b0;
		assert (ferrCount == base + 1) else flagMismatch(base + 1, ferrCount);
		endTest();

		startTest("glitch rejection");
		base = rdPtr;
		eopBase = eopCount;
		lineDrv = 1'b0;
		waitClocks(BIT_CLKS / `UART_OVERSAMPLE);	// one oversample tick
		lineDrv = 1'b1;
		waitClocks(20 * BIT_CLKS);
		assert (rdPtr == base) else flagMismatch(base, rdPtr);
		// a woken receiver drops rxIdle and raises a fresh end of packet
		assert (rxIdle === 1'b1 && eopCount == eopBase)
			else flagError("glitch woke the receiver");
		endTest();

		startTest("busy request ignored");
		loopback = 1'b1;
		drawByte(b);
		sendByte(b);
		waitClocks(3 * BIT_CLKS);
		assert (txBusy === 1'b1) else flagMismatch(1, txBusy);
		pulseStart(~b);	// must be dropped
		waitRx(wrPtr);
		waitClocks(2 * BIT_CLKS);	// a queued request would be on the line by now
		assert (txBusy === 1'b0) else flagError("second request started a frame");
		waitClocks(10 * BIT_CLKS);
		assert (rdPtr == wrPtr) else flagMismatch(wrPtr, rdPtr);
		endTest();

		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: all.f
+incdir+hw
hw/uartPkg.sv
hw/baudTickGen.sv
hw/uartReceiver.sv
hw/uartTransmitter.sv
hw/uartPort.sv
dv/uartPortTb.sv

// File: run.sh
#!/bin/sh
# build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module uartPortTb -o simv
out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
